// File: lpcAutocorr.f
+incdir+tb
source/lpcDspPkg.sv
source/lpcBusPkg.sv
source/apbRegIf.sv
source/preFilter.sv
source/frameBuffer.sv
source/autocorrEngine.sv
source/lagResultBank.sv
source/lpcAutocorrTop.sv
tb/lpcAutocorr_asserts.sv
tb/lpcAutocorrTb.sv

// File: source/apbRegIf.sv
module apbRegIf #(
	parameter int LAG_COUNT = 11
) (
	input logic mclk,
	input logic reset,
	input lpcBusPkg::apbReq_t apbReq,
	input logic filtBusy,
	input logic frameFull,
	input lpcDspPkg::acc_t lagData,
	input logic resultsValid,
	input logic [7:0] frameCount,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output lpcDspPkg::filtBeat_t sampleIn,
	output logic [3:0] lagIndex
);
	import lpcBusPkg::*;

	regSel_t regSel;
	logic [7:0] lagOffset;
	logic lagHit;
	logic access;
	logic sampleWr;
	logic busy;
	logic stall;
	logic badAccess;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	assign lagOffset = apbReq.paddr - ADDR_LAG_BASE;
	assign lagIndex = lagOffset[5:2];
	// Word aligned, inside the lag window and below LAG_COUNT
	assign lagHit = (apbReq.paddr >= ADDR_LAG_BASE) && (lagOffset[7:6] == 2'b00)
		&& (lagOffset[1:0] == 2'b00) && (lagOffset[5:2] < LAG_COUNT);

	always_comb
	begin
		if (apbReq.paddr == ADDR_SAMPLE)
			regSel = REG_SAMPLE;
		else if (apbReq.paddr == ADDR_STATUS)
			regSel = REG_STATUS;
		else if (lagHit)
			regSel = REG_LAG;
		else
			regSel = REG_NONE;
	end

	//////////////////////////////
	// Handshake and errors
	//////////////////////////////

	assign access = apbReq.psel && apbReq.penable;
	assign sampleWr = access && apbReq.pwrite && (regSel == REG_SAMPLE);
	assign busy = filtBusy || frameFull;
	// Only sample writes ever wait
	assign stall = sampleWr && busy;
	assign pready = access && !stall;
	assign pslverr = pready && badAccess;

	always_comb
	begin
		case (regSel)
			REG_SAMPLE: badAccess = !apbReq.pwrite;
			REG_STATUS, REG_LAG: badAccess = apbReq.pwrite;
			default: badAccess = 1'b1;
		endcase
	end

	// Read data mux
	always_comb
	begin
		prdata = '0;
		if (access && !apbReq.pwrite)
		begin
			case (regSel)
				REG_STATUS: prdata = {16'h0, frameCount, 6'h0, busy, resultsValid};
				REG_LAG: prdata = lagData;
				default: prdata = '0;
			endcase
		end
	end

	// Accepted sample goes to the filter one cycle later
	always_ff @(posedge mclk)
	begin
		if (reset)
			sampleIn.valid <= 1'b0;
		else
			sampleIn.valid <= sampleWr && !busy;
		if (sampleWr && !busy)
			sampleIn.data <= apbReq.pwdata[15:0];
	end

endmodule

// File: source/autocorrEngine.sv
module autocorrEngine #(
	parameter int FRAME_LEN = 80,
	parameter int LAG_COUNT = 11
) (
	input logic mclk,
	input logic reset,
	input logic frameFull,
	input lpcDspPkg::sample_t rdData,
	output logic [6:0] rdIndex,
	output logic frameRelease,
	output lpcDspPkg::lagBeat_t lagWrite,
	output logic frameDone
);
	import lpcDspPkg::*;

	typedef enum logic [2:0] {IDLE, FETCH, MAC, STORE, RELEASE} engState_t;

	localparam logic [6:0] LAST_N = 7'(FRAME_LEN - 1);
	localparam logic [3:0] LAST_K = 4'(LAG_COUNT - 1);
	localparam logic signed [33:0] SAT_MAX = 34'sd2147483647;
	localparam logic signed [33:0] SAT_MIN = -34'sd2147483648;

	engState_t state;
	logic [3:0] lagK;
	logic [6:0] n;
	sample_t yCur;
	acc_t accum;
	acc_t pairProd;
	acc_t accNext;
	logic signed [33:0] sum;

	// FETCH reads y[n], MAC reads y[n-k]
	assign rdIndex = (state == MAC) ? (n - 7'(lagK)) : n;

	//////////////////////////////
	// Multiply-accumulate
	//////////////////////////////

	assign pairProd = yCur * rdData;
	// Doubled product added in a wide sum, clamped back to 32 bits
	assign sum = 34'(accum) + 34'(pairProd) + 34'(pairProd);

	always_comb
	begin
		if (sum > SAT_MAX)
			accNext = 32'sh7fffffff;
		else if (sum < SAT_MIN)
			accNext = 32'sh80000000;
		else
			accNext = sum[31:0];
	end

	assign lagWrite = '{valid: (state == STORE), index: lagK, value: accum};
	assign frameDone = (state == STORE) && (lagK == LAST_K);
	assign frameRelease = (state == RELEASE);

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			state <= IDLE;
			lagK <= '0;
			n <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (frameFull)
					begin
						lagK <= '0;
						n <= '0;
						state <= FETCH;
					end
				end
				FETCH: state <= MAC;
				MAC:
				begin
					if (n == LAST_N)
						state <= STORE;
					else
					begin
						n <= n + 7'd1;
						state <= FETCH;
					end
				end
				STORE:
				begin
					if (lagK == LAST_K)
						state <= RELEASE;
					else
					begin
						// Next lag starts its sum at n = k
						lagK <= lagK + 4'd1;
						n <= 7'(lagK) + 7'd1;
						state <= FETCH;
					end
				end
				RELEASE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge mclk)
	begin
		case (state)
			FETCH: yCur <= rdData;
			MAC: accum <= accNext;
			default: accum <= '0;
		endcase
	end

endmodule

// File: source/frameBuffer.sv
module frameBuffer #(
	parameter int FRAME_LEN = 80
) (
	input logic mclk,
	input logic reset,
	input lpcDspPkg::filtBeat_t filtIn,
	input logic [6:0] rdIndex,
	input logic frameRelease,
	output lpcDspPkg::sample_t rdData,
	output logic frameFull
);
	import lpcDspPkg::*;

	localparam logic [6:0] LAST_SLOT = 7'(FRAME_LEN - 1);

	sample_t store [FRAME_LEN];
	logic [6:0] wrPtr;
	logic wrEn;

	// Writes are refused while the engine owns the frame
	assign wrEn = filtIn.valid && !frameFull;

	//////////////////////////////
	// Sample store
	//////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (wrEn)
			store[wrPtr] <= filtIn.data;
	end

	// Engine reads are asynchronous
	assign rdData = store[rdIndex];

	//////////////////////////////
	// Fill pointer and ownership
	//////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			frameFull <= 1'b0;
		end
		else if (frameRelease)
		begin
			wrPtr <= '0;
			frameFull <= 1'b0;
		end
		else if (wrEn)
		begin
			if (wrPtr == LAST_SLOT)
			begin
				wrPtr <= '0;
				frameFull <= 1'b1;
			end
			else
				wrPtr <= wrPtr + 7'd1;
		end
	end

endmodule

// File: source/lagResultBank.sv
module lagResultBank #(
	parameter int LAG_COUNT = 11
) (
	input logic mclk,
	input logic reset,
	input lpcDspPkg::lagBeat_t lagWrite,
	input logic frameDone,
	input logic [3:0] lagIndex,
	output lpcDspPkg::acc_t lagData,
	output logic resultsValid,
	output logic [7:0] frameCount
);
	import lpcDspPkg::*;

	acc_t lags [LAG_COUNT];

	// Latest lag set, overwritten as the engine finishes each lag
	always_ff @(posedge mclk)
	begin
		if (lagWrite.valid && (lagWrite.index < LAG_COUNT))
			lags[lagWrite.index] <= lagWrite.value;
	end

	// Out of range reads return zero
	assign lagData = (lagIndex < LAG_COUNT) ? lags[lagIndex] : '0;

	// Frame counter wraps at 256
	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			resultsValid <= 1'b0;
			frameCount <= '0;
		end
		else if (frameDone)
		begin
			resultsValid <= 1'b1;
			frameCount <= frameCount + 8'd1;
		end
	end

endmodule

// File: source/lpcAutocorrTop.sv
module lpcAutocorrTop #(
	parameter int FRAME_LEN = 80,
	parameter int LAG_COUNT = 11
) (
	input logic mclk,
	input logic reset,
	input lpcBusPkg::apbReq_t apbReq,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import lpcDspPkg::*;

	filtBeat_t sampleIn;
	filtBeat_t filtOut;
	lagBeat_t lagWrite;
	sample_t rdData;
	acc_t lagData;
	logic filtBusy;
	logic frameFull;
	logic frameRelease;
	logic frameDone;
	logic resultsValid;
	logic [6:0] rdIndex;
	logic [3:0] lagIndex;
	logic [7:0] frameCount;

	//////////////////////////////
	// Bus side
	//////////////////////////////

	apbRegIf #(.LAG_COUNT(LAG_COUNT)) uRegIf (
		.mclk(mclk),
		.reset(reset),
		.apbReq(apbReq),
		.filtBusy(filtBusy),
		.frameFull(frameFull),
		.lagData(lagData),
		.resultsValid(resultsValid),
		.frameCount(frameCount),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sampleIn(sampleIn),
		.lagIndex(lagIndex)
	);

	//////////////////////////////
	// Processing chain
	//////////////////////////////

	preFilter uFilter (
		.mclk(mclk),
		.reset(reset),
		.sampleIn(sampleIn),
		.filtOut(filtOut),
		.filtBusy(filtBusy)
	);

	frameBuffer #(.FRAME_LEN(FRAME_LEN)) uFrame (
		.mclk(mclk),
		.reset(reset),
		.filtIn(filtOut),
		.rdIndex(rdIndex),
		.frameRelease(frameRelease),
		.rdData(rdData),
		.frameFull(frameFull)
	);

	autocorrEngine #(.FRAME_LEN(FRAME_LEN), .LAG_COUNT(LAG_COUNT)) uEngine (
		.mclk(mclk),
		.reset(reset),
		.frameFull(frameFull),
		.rdData(rdData),
		.rdIndex(rdIndex),
		.frameRelease(frameRelease),
		.lagWrite(lagWrite),
		.frameDone(frameDone)
	);

	lagResultBank #(.LAG_COUNT(LAG_COUNT)) uBank (
		.mclk(mclk),
		.reset(reset),
		.lagWrite(lagWrite),
		.frameDone(frameDone),
		.lagIndex(lagIndex),
		.lagData(lagData),
		.resultsValid(resultsValid),
		.frameCount(frameCount)
	);

endmodule

// File: source/lpcBusPkg.sv
package lpcBusPkg;

	//////////////////////////////
	// APB request from the master
	//////////////////////////////

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	// Decoded register targets
	typedef enum logic [1:0] {
		REG_SAMPLE,
		REG_STATUS,
		REG_LAG,
		REG_NONE
	} regSel_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam logic [7:0] ADDR_SAMPLE = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;
	// Lag k sits at base + 4k
	localparam logic [7:0] ADDR_LAG_BASE = 8'h40;

endpackage

// File: source/lpcDspPkg.sv
package lpcDspPkg;

	//////////////////////////////
	// Sample and accumulator types
	//////////////////////////////

	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;

	// One filtered sample on its way into the frame store
	typedef struct packed {
		logic valid;
		sample_t data;
	} filtBeat_t;

	// Finished lag from the engine to the result bank
	typedef struct packed {
		logic valid;
		logic [3:0] index;
		acc_t value;
	} lagBeat_t;

	//////////////////////////////
	// High-pass coefficients, Q12
	//////////////////////////////

	localparam sample_t FILT_B0 = 16'sd1899;
	localparam sample_t FILT_B1 = -16'sd3798;
	localparam sample_t FILT_B2 = 16'sd1899;
	localparam sample_t FILT_A1 = 16'sd7807;
	localparam sample_t FILT_A2 = -16'sd3733;

endpackage

// File: source/preFilter.sv
module preFilter (
	input logic mclk,
	input logic reset,
	input lpcDspPkg::filtBeat_t sampleIn,
	output lpcDspPkg::filtBeat_t filtOut,
	output logic filtBusy
);
	import lpcDspPkg::*;

	typedef enum logic [2:0] {F_IDLE, F_B0, F_B1, F_B2, F_A1, F_A2, F_OUT} filtState_t;

	filtState_t state;
	sample_t xHalf;
	sample_t xHalf1;
	sample_t xHalf2;
	sample_t y1;
	sample_t y2;
	sample_t mulA;
	sample_t mulB;
	sample_t yOut;
	acc_t product;
	acc_t acc;
	acc_t rounded;
	acc_t shifted;

	// One shared multiplier, operands picked by step
	always_comb
	begin
		mulA = '0;
		mulB = '0;
		case (state)
			F_B0:
			begin
				mulA = FILT_B0;
				mulB = xHalf;
			end
			F_B1:
			begin
				mulA = FILT_B1;
				mulB = xHalf1;
			end
			F_B2:
			begin
				mulA = FILT_B2;
				mulB = xHalf2;
			end
			F_A1:
			begin
				mulA = FILT_A1;
				mulB = y1;
			end
			F_A2:
			begin
				mulA = FILT_A2;
				mulB = y2;
			end
			default:
			begin
				mulA = '0;
				mulB = '0;
			end
		endcase
	end

	assign product = mulA * mulB;

	// Round Q12 back to Q0, then clamp to 16 bits
	assign rounded = acc + 32'sd2048;
	assign shifted = rounded >>> 12;

	always_comb
	begin
		if (shifted > 32'sd32767)
			yOut = 16'sh7fff;
		else if (shifted < -32'sd32768)
			yOut = 16'sh8000;
		else
			yOut = shifted[15:0];
	end

	assign filtOut = '{valid: (state == F_OUT), data: yOut};
	assign filtBusy = (state != F_IDLE);

	//////////////////////////////
	// Step sequencer and history
	//////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			state <= F_IDLE;
			xHalf1 <= '0;
			xHalf2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end
		else
		begin
			case (state)
				F_IDLE: if (sampleIn.valid) state <= F_B0;
				F_B0: state <= F_B1;
				F_B1: state <= F_B2;
				F_B2: state <= F_A1;
				F_A1: state <= F_A2;
				F_A2: state <= F_OUT;
				F_OUT:
				begin
					xHalf2 <= xHalf1;
					xHalf1 <= xHalf;
					y2 <= y1;
					y1 <= yOut;
					state <= F_IDLE;
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge mclk)
	begin
		if (state == F_IDLE && sampleIn.valid)
			xHalf <= sampleIn.data >>> 1;
		if (state == F_B0)
			acc <= product;
		else if (state != F_IDLE && state != F_OUT)
			acc <= acc + product;
	end

endmodule

// File: tb/lpcModel.svh
`ifndef LPC_MODEL_SVH
`define LPC_MODEL_SVH

localparam longint LAG_MAX = 64'sh7fffffff;
localparam longint LAG_MIN = -64'sh80000000;

// Filter history, halved inputs and past outputs
int histX1;
int histX2;
int histY1;
int histY2;
// Filtered frame as the frame store should hold it
int modelY [FRAME_LEN];

function automatic int clampTo(input longint v, input longint lo, input longint hi);
	if (v > hi)
		return int'(hi);
	else if (v < lo)
		return int'(lo);
	return int'(v);
endfunction

// One high-pass step in Q12, history carried across calls
function automatic int filterSample(input int x);
	int xh;
	int y;
	longint acc;
	xh = x >>> 1;
	acc = longint'(FILT_B0) * xh + longint'(FILT_B1) * histX1 + longint'(FILT_B2) * histX2
		+ longint'(FILT_A1) * histY1 + longint'(FILT_A2) * histY2;
	y = clampTo((acc + 2048) >>> 12, -32768, 32767);
	histX2 = histX1;
	histX1 = xh;
	histY2 = histY1;
	histY1 = y;
	return y;
endfunction

// Lag k, doubled products, clamped after every addition
function automatic int lagValue(input int k);
	longint s;
	int n;
	s = 0;
	for (n = k; n < FRAME_LEN; n++)
		s = clampTo(s + 2 * longint'(modelY[n]) * longint'(modelY[n - k]), LAG_MIN, LAG_MAX);
	return int'(s);
endfunction

`endif

// File: tb/lpcAutocorrTb.sv
module lpcAutocorrTb;
	timeunit 1ns;
	timeprecision 1ns;
	import lpcDspPkg::*;
	import lpcBusPkg::*;

	localparam int FRAME_LEN = 80;
	localparam int LAG_COUNT = 11;
	localparam int CLK_PERIOD = 100;
	localparam int FRAME_TOTAL = 3;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL} tbOp_t;

	// One APB transfer with its expected response
	typedef struct packed {
		tbOp_t op;
		logic [2:0] testId;
		logic checkData;
		logic expErr;
		logic [7:0] addr;
		logic [31:0] data;
		logic [31:0] expData;
	} stimRow_t;

	logic mclk;
	logic reset;
	apbReq_t apbReq;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	stimRow_t stimTable [$];
	int tableRows;
	int seed;
	int waitStates;
	int samplesAccepted;
	int testErrors;
	int testsPassed;
	int testsFailed;

	`include "lpcModel.svh"

	lpcAutocorrTop #(.FRAME_LEN(FRAME_LEN), .LAG_COUNT(LAG_COUNT)) u_dut (
		.mclk(mclk),
		.reset(reset),
		.apbReq(apbReq),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		mclk = 1'b0;
		forever #(CLK_PERIOD / 2) mclk = ~mclk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [7:0] lagAddr(input int k);
		return ADDR_LAG_BASE + 8'(4 * k);
	endfunction

	function automatic string regName(input logic [7:0] addr);
		if (addr == ADDR_STATUS)
			return "prdata STATUS";
		else if (addr >= ADDR_LAG_BASE)
			return $sformatf("prdata lag%0d", (addr - ADDR_LAG_BASE) / 4);
		return $sformatf("prdata @%h", addr);
	endfunction

	function automatic string testName(input int id);
		case (id)
			1: return "status after reset";
			2: return "first frame lags";
			3: return "second frame keeps filter history";
			4: return "full-scale saturation";
			5: return "slave errors leave results intact";
			default: return "back-to-back sample writes";
		endcase
	endfunction

	task automatic addRow(input tbOp_t op, input int testId, input logic [7:0] addr,
		input logic [31:0] data, input logic [31:0] expData, input logic checkData,
		input logic expErr);
		stimTable.push_back('{op, 3'(testId), checkData, expErr, addr, data, expData});
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	task automatic finishTest(input int id);
		if (testErrors == 0)
		begin
			testsPassed++;
			$display("[%0d] %s: PASS", id, testName(id));
		end
		else
		begin
			testsFailed++;
			$display("[%0d] %s: %0d mismatches", id, testName(id), testErrors);
		end
		testErrors = 0;
	endtask

	// Samples, model results and table rows for one frame
	task automatic buildFrame(input int testId, input logic fullScale, input int frameNo);
		int i;
		int s;
		logic [31:0] expLag;
		logic [31:0] expStatus;
		expStatus = {16'h0, 8'(frameNo), 8'h01};
		for (i = 0; i < FRAME_LEN; i++)
		begin
			if (fullScale)
				s = ((i / 4) % 2 == 0) ? 32767 : -32768;
			else
				s = $random(seed) % 4096;
			modelY[i] = filterSample(s);
			addRow(OP_WRITE, testId, ADDR_SAMPLE, 32'(s), '0, 1'b0, 1'b0);
		end
		addRow(OP_POLL, testId, ADDR_STATUS, '0, expStatus, 1'b1, 1'b0);
		for (i = 0; i < LAG_COUNT; i++)
		begin
			expLag = lagValue(i);
			if (fullScale && i == 0)
				expLag = 32'h7fffffff;
			addRow(OP_READ, testId, lagAddr(i), '0, expLag, 1'b1, 1'b0);
		end
		addRow(OP_READ, testId, ADDR_STATUS, '0, expStatus, 1'b1, 1'b0);
	endtask

	// Setup, then access until pready; outputs sampled mid-cycle
	task automatic apbTransfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge mclk);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge mclk);
		apbReq.penable <= 1'b1;
		@(negedge mclk);
		while (!pready)
		begin
			waitStates++;
			@(negedge mclk);
		end
		rdata = prdata;
		err = pslverr;
	endtask

	task automatic applyRow(input stimRow_t row);
		logic [31:0] rdata;
		logic err;
		apbTransfer(row.op == OP_WRITE, row.addr, row.data, rdata, err);
		// Keep reading STATUS until results are valid and the chain is idle
		if (row.op == OP_POLL)
		begin
			while (rdata[1] || !rdata[0])
				apbTransfer(1'b0, row.addr, '0, rdata, err);
		end
		if (row.op == OP_WRITE && row.addr == ADDR_SAMPLE && !err)
			samplesAccepted++;
		if (row.checkData)
			checkValue(regName(row.addr), rdata, row.expData);
		checkValue($sformatf("pslverr @%h", row.addr), 32'(err), 32'(row.expErr));
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int i;
		int k;
		int lastLagRow;
		apbReq = '0;
		reset = 1'b1;
		seed = 32'h7d72;

		addRow(OP_READ, 1, ADDR_STATUS, '0, '0, 1'b1, 1'b0);
		buildFrame(2, 1'b0, 1);
		buildFrame(3, 1'b0, 2);
		buildFrame(4, 1'b1, 3);
		// First lag row of the last frame, ahead of its closing STATUS row
		lastLagRow = stimTable.size() - LAG_COUNT - 1;
		addRow(OP_READ, 5, 8'h08, '0, '0, 1'b0, 1'b1);
		addRow(OP_WRITE, 5, ADDR_STATUS, 32'h1, '0, 1'b0, 1'b1);
		addRow(OP_READ, 5, lagAddr(LAG_COUNT), '0, '0, 1'b0, 1'b1);
		addRow(OP_READ, 5, ADDR_SAMPLE, '0, '0, 1'b0, 1'b1);
		// Lags of the last frame must survive the errors
		for (k = 0; k < LAG_COUNT; k++)
			addRow(OP_READ, 5, lagAddr(k), '0, stimTable[lastLagRow + k].expData,
				1'b1, 1'b0);
		addRow(OP_READ, 5, ADDR_STATUS, '0, 32'h0301, 1'b1, 1'b0);
		tableRows = stimTable.size();

		repeat (8) @(posedge mclk);
		reset <= 1'b0;

		for (i = 0; i < tableRows; i++)
		begin
			if (i > 0 && stimTable[i].testId != stimTable[i - 1].testId)
				finishTest(stimTable[i - 1].testId);
			applyRow(stimTable[i]);
		end
		@(posedge mclk);
		apbReq <= '0;
		finishTest(stimTable[tableRows - 1].testId);

		// Stalled writes still all land, lag matches above confirm order
		checkValue("samples accepted", samplesAccepted, FRAME_TOTAL * FRAME_LEN);
		checkValue("wait states seen", 32'(waitStates > 0), 32'd1);
		checkValue("APB assertion failures", u_dut.uRegIf.uAsserts.assertFails, 0);
		finishTest(6);

		$display("summary: %0d passed, %0d failed", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog scaled by table length and engine latency
	initial
	begin
		wait (tableRows > 0);
		repeat (tableRows * FRAME_LEN * LAG_COUNT * 2) @(posedge mclk);
		$display("timeout: run did not finish within %0d clock periods",
			tableRows * FRAME_LEN * LAG_COUNT * 2);
		$display("test failed");
		$finish;
	end

endmodule

// File: tb/lpcAutocorr_asserts.sv
module lpcAutocorr_asserts (
	input logic mclk,
	input logic reset,
	input lpcBusPkg::apbReq_t apbReq,
	input logic pready,
	input logic pslverr,
	input lpcDspPkg::filtBeat_t sampleIn,
	input logic filtBusy
);
	timeunit 1ns;
	timeprecision 1ns;
	import lpcBusPkg::*;

	int assertFails;
	logic sampleDone;

	// Sample write completing on this edge
	assign sampleDone = apbReq.psel && apbReq.penable && apbReq.pwrite
		&& (apbReq.paddr == ADDR_SAMPLE) && pready;

	// An error response never hands a sample to the filter
	errNoSample: assert property (@(posedge mclk) disable iff (reset)
		pslverr |=> !sampleIn.valid)
	else
	begin
		$error("slave error passed a sample to the filter");
		assertFails++;
	end

	// Master holds the request through wait states
	holdWhileWait: assert property (@(posedge mclk) disable iff (reset)
		(apbReq.psel && apbReq.penable && !pready) |=> $stable(apbReq))
	else
	begin
		$error("APB request changed during a wait state");
		assertFails++;
	end

	// Accepted sample reaches the filter, which then starts on it
	sampleToFilter: assert property (@(posedge mclk) disable iff (reset)
		sampleDone |-> ##2 filtBusy)
	else
	begin
		$error("accepted sample did not start the filter");
		assertFails++;
	end

endmodule

bind apbRegIf lpcAutocorr_asserts uAsserts (
	.mclk(mclk),
	.reset(reset),
	.apbReq(apbReq),
	.pready(pready),
	.pslverr(pslverr),
	.sampleIn(sampleIn),
	.filtBusy(filtBusy)
);
